// ==== icache_top.f ====
source/icache_pkg.sv
source/icache_fetch_port.sv
source/icache_store.sv
source/icache_plru.sv
source/icache_refill.sv
source/icache_top.sv
sim/tb_line_mem.sv
sim/tb_icache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs tb_icache_top with Verilator, once with the cache on and once with it off
cd "$(dirname "$0")" || exit 1

run_case() {
  en="$1"
  mdir="obj_dir_en$en"
  echo "=== cache_en=$en ==="
  if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
      --top-module tb_icache_top -Gcache_en="$en" --Mdir "$mdir" -f icache_top.f; then
    echo "compile failed for cache_en=$en"
    return 1
  fi
  out=$("./$mdir/Vtb_icache_top" 2>&1)
  status=$?
  printf '%s\n' "$out"
  if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status for cache_en=$en"
    return 1
  fi
  if ! printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    echo "pass line not found in the output for cache_en=$en"
    return 1
  fi
  return 0
}

result=0
run_case 1 || result=1
run_case 0 || result=1
exit "$result"

// ==== sim/tb_icache_top.sv ====
// stops at the first error; the replacement model only predicts hits when cache_en is set
`timescale 1ns/1ns

module tb_icache_top #(
  parameter int n_ways   = 4,
  parameter bit cache_en = 1'b1
);

  localparam int          n_access = 240;        // bound on accesses over all tests
  localparam int          max_wait = 8 + 4 * 4;  // cycles for one refill, worst case
  localparam logic [31:0] seed     = 32'heb67a282;

  logic                          clk;
  logic                          rst;
  logic                          req_valid;
  icache_pkg::fetch_req_t        req;
  logic                          rsp_valid;
  icache_pkg::fetch_rsp_t        rsp;
  logic                          mem_req;
  logic [icache_pkg::word_w-1:0] mem_addr;
  logic                          beat_valid;
  icache_pkg::mem_beat_t         beat;
  logic [31:0]                   lfsr_q;
  int                            cyc;            // rising edges so far
  int                            last_beat_cyc;
  logic [icache_pkg::tag_w-1:0]  model_tag [n_ways];
  logic [n_ways-1:0]             model_valid;
  logic [n_ways-1:0]             model_used;
  logic [icache_pkg::tag_w-1:0]  evicted_tag;     // line pushed out by the last model miss

  icache_top #(.n_ways(n_ways), .cache_en(cache_en)) dut0 (
    .clk, .rst,
    .req_valid_i(req_valid), .req_i(req),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr),
    .mem_beat_valid_i(beat_valid), .mem_beat_i(beat)
  );

  tb_line_mem #(.seed(seed)) mem0 (
    .clk, .mem_req_i(mem_req), .mem_addr_i(mem_addr),
    .beat_valid_o(beat_valid), .beat_o(beat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (beat_valid && beat.idx == icache_pkg::off_w'(icache_pkg::line_words - 1)) begin
      last_beat_cyc <= cyc;  // fourth beat taken here
    end
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return r;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_rsp(input icache_pkg::fetch_rsp_t got, input icache_pkg::fetch_rsp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: response data %h, expected %h",
                         $time, got.data, exp.data));
    end
  endtask

  task automatic compare_mem_addr(input logic [icache_pkg::word_w-1:0] got,
                                  input logic [icache_pkg::word_w-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: line address %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic compare_miss(input bit got, input bit exp);
    if (got != exp) begin
      stop_run($sformatf("mismatch at %0t: access %s, expected %s", $time,
                         got ? "missed" : "hit", exp ? "a miss" : "a hit"));
    end
  endtask

  function automatic int model_find(input logic [icache_pkg::tag_w-1:0] tag);
    for (int w = 0; w < n_ways; w++) begin
      if (model_valid[w] && model_tag[w] == tag) return w;
    end
    return -1;
  endfunction

  // lowest invalid way, else lowest way with used clear; all used keeps only the newest
  task automatic model_access(input logic [icache_pkg::tag_w-1:0] tag, output bit miss);
    int way;
    way  = model_find(tag);
    miss = !cache_en || way < 0;
    if (cache_en) begin
      if (way < 0) begin
        way = n_ways;
        for (int w = n_ways - 1; w >= 0; w--) begin
          if (!model_valid[w]) way = w;
        end
        if (way == n_ways) begin
          for (int w = n_ways - 1; w >= 0; w--) begin
            if (!model_used[w]) way = w;
          end
        end
        evicted_tag      = model_tag[way];
        model_tag[way]   = tag;
        model_valid[way] = 1'b1;
      end
      model_used[way] = 1'b1;
      if (&model_used) begin
        model_used      = '0;
        model_used[way] = 1'b1;
      end
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst         = 1'b0;
    model_valid = '0;
    model_used  = '0;
    if (rsp_valid || mem_req) stop_run("response or memory request active right after reset");
  endtask

  // one request from a falling edge; hit or miss, line address, latency and data
  task automatic access(input logic [31:0] addr);
    bit                     exp_miss;
    bit                     got_miss;
    int                     waited;
    icache_pkg::fetch_rsp_t exp_rsp;
    model_access(addr[31:2], exp_miss);
    exp_rsp.data = expected_word(addr);
    req_valid    = 1'b1;
    req.addr     = addr;
    @(negedge clk);
    req_valid = 1'b0;
    got_miss  = mem_req;
    compare_miss(got_miss, exp_miss);
    if (got_miss) compare_mem_addr(mem_addr, {addr[31:2], 2'b00});
    waited = 0;
    while (!rsp_valid) begin
      @(negedge clk);
      waited++;
      if (waited > max_wait) stop_run("no response arrived within the refill time limit");
    end
    if (!got_miss && waited != 0) begin
      stop_run($sformatf("mismatch at %0t: hit answered after %0d cycles, expected 1",
                         $time, waited + 1));
    end
    if (got_miss && cyc != last_beat_cyc + 1) begin
      stop_run($sformatf("mismatch at %0t: response %0d cycles after the fourth beat, expected 1",
                         $time, cyc - last_beat_cyc));
    end
    compare_rsp(rsp, exp_rsp);
    @(negedge clk);  // fetch port back in IDLE
  endtask

  task automatic test_cold_miss();
    access(32'h0000_1001);
  endtask

  task automatic test_line_hits();
    for (int i = 0; i < icache_pkg::line_words; i++) access(32'h0000_1000 + 32'(i));
  endtask

  task automatic test_replacement();
    logic [31:0] victim_addr;
    apply_reset();
    for (int i = 0; i < n_ways; i++) access(32'h0002_0000 + 32'(4 * i));
    access(32'h0002_0000);                               // touch line 0
    access(32'h0002_0002 + 32'(4 * (n_ways - 1)));       // touch the last line
    access(32'h0002_0000 + 32'(4 * n_ways));             // new line evicts one
    if (cache_en) begin
      victim_addr = {evicted_tag, 2'b11};
      access(victim_addr);  // must miss again
    end
  endtask

  task automatic test_reset();
    access(32'h0003_0004);
    access(32'h0003_0005);
    apply_reset();
    access(32'h0003_0004);  // contents gone, misses again
  endtask

  task automatic test_random_stream();
    logic [31:0] line;
    logic [31:0] word;
    for (int i = 0; i < 200; i++) begin
      line = take_bits(3);  // eight lines in play
      word = take_bits(2);
      access(32'h0004_0000 + line * 4 + word);
    end
  endtask

  initial begin
    #(n_access * max_wait * 8 + 2000);
    stop_run("watchdog expired before the tests finished");
  end

  initial begin
    lfsr_q    = seed;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    apply_reset();
    test_cold_miss();
    test_line_hits();
    test_replacement();
    test_reset();
    test_random_stream();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== sim/tb_line_mem.sv ====
// one line read at a time; beats 0..3 in order, gaps of 0 to 3 cycles, driven on the falling edge
`timescale 1ns/1ns

module tb_line_mem #(
  parameter logic [31:0] seed = 32'heb67a282
) (
  input  logic                          clk,
  input  logic                          mem_req_i,
  input  logic [icache_pkg::word_w-1:0] mem_addr_i,
  output logic                          beat_valid_o,
  output icache_pkg::mem_beat_t         beat_o
);

  logic [31:0] lfsr_q;

  // memory contents follow the address, no storage needed
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ 32'h3c5a_96e1;
  endfunction

  // galois lfsr, one step per bit
  function automatic logic [1:0] next_gap();
    logic [1:0] g;
    g = '0;
    for (int i = 0; i < 2; i++) begin
      g      = {g[0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return g;
  endfunction

  initial begin
    logic [31:0] base;
    logic [1:0]  gap;
    lfsr_q       = seed;
    beat_valid_o = 1'b0;
    beat_o       = '0;
    forever begin
      @(negedge clk);
      if (mem_req_i) begin
        base = mem_addr_i;
        for (int b = 0; b < icache_pkg::line_words; b++) begin
          gap = next_gap();
          @(negedge clk);  // first beat never in the request cycle
          beat_valid_o = 1'b0;
          repeat (gap) @(negedge clk);
          beat_valid_o = 1'b1;
          beat_o.idx   = icache_pkg::off_w'(b);
          beat_o.data  = mem_word(base + 32'(b));
        end
        @(negedge clk);
        beat_valid_o = 1'b0;
      end
    end
  end

endmodule

// ==== source/icache_top.sv ====
// n_ways 2, 4 or 8; cache_en 0 makes every access a miss and installs nothing
`timescale 1ns/1ns

module icache_top #(
  parameter int n_ways   = 4,
  parameter bit cache_en = 1'b1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  input  icache_pkg::fetch_req_t        req_i,
  output logic                          rsp_valid_o,
  output icache_pkg::fetch_rsp_t        rsp_o,
  output logic                          mem_req_o,
  output logic [icache_pkg::word_w-1:0] mem_addr_o,
  input  logic                          mem_beat_valid_i,
  input  icache_pkg::mem_beat_t         mem_beat_i
);

  logic [icache_pkg::tag_w-1:0]  lookup_tag;
  logic [icache_pkg::off_w-1:0]  lookup_offset;
  logic                          hit;
  logic [n_ways-1:0]             hit_way;
  logic [icache_pkg::word_w-1:0] hit_word;
  logic                          touch;
  logic                          refill_start;
  logic [icache_pkg::tag_w-1:0]  refill_tag;
  logic                          fill_valid;
  icache_pkg::line_fill_t        fill;
  logic [n_ways-1:0]             valid;
  logic [n_ways-1:0]             victim;

  icache_fetch_port #(.cache_en(cache_en)) u_fetch_port (
    .clk, .rst,
    .req_valid_i, .req_i,
    .rsp_valid_o, .rsp_o,
    .lookup_tag_o(lookup_tag), .lookup_offset_o(lookup_offset),
    .hit_i(hit), .hit_word_i(hit_word),
    .touch_o(touch),
    .refill_start_o(refill_start), .refill_tag_o(refill_tag),
    .fill_valid_i(fill_valid), .fill_i(fill)
  );

  icache_store #(.n_ways(n_ways), .cache_en(cache_en)) u_store (
    .clk,
    .lookup_tag_i(lookup_tag), .lookup_offset_i(lookup_offset),
    .valid_i(valid), .victim_i(victim),
    .fill_valid_i(fill_valid), .fill_i(fill),
    .hit_o(hit), .hit_way_o(hit_way), .hit_word_o(hit_word)
  );

  icache_plru #(.n_ways(n_ways)) u_plru (
    .clk, .rst,
    .touch_i(touch), .hit_way_i(hit_way),
    .fill_valid_i(fill_valid),
    .valid_o(valid), .victim_o(victim)
  );

  icache_refill u_refill (
    .clk, .rst,
    .refill_start_i(refill_start), .refill_tag_i(refill_tag),
    .mem_req_o, .mem_addr_o,
    .mem_beat_valid_i, .mem_beat_i,
    .fill_valid_o(fill_valid), .fill_o(fill)
  );

endmodule

// ==== source/icache_refill.sv ====
// one line read at a time; beats must come in order 0..3 and only after mem_req_o
`timescale 1ns/1ns

module icache_refill (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          refill_start_i,
  input  logic [icache_pkg::tag_w-1:0]  refill_tag_i,
  output logic                          mem_req_o,
  output logic [icache_pkg::word_w-1:0] mem_addr_o,
  input  logic                          mem_beat_valid_i,
  input  icache_pkg::mem_beat_t         mem_beat_i,
  output logic                          fill_valid_o,
  output icache_pkg::line_fill_t        fill_o
);

  logic                          busy_q;     // line read outstanding
  logic [icache_pkg::off_w-1:0]  cnt_q;      // next expected beat
  logic [icache_pkg::tag_w-1:0]  tag_q;
  logic [icache_pkg::line_w-1:0] line_q;     // beats gathered so far
  logic [icache_pkg::line_w-1:0] line_next;
  logic                          beat_take;
  logic                          last_beat;

  // request goes out in the same cycle as the miss
  assign mem_req_o  = refill_start_i;
  assign mem_addr_o = {refill_tag_i, {icache_pkg::off_w{1'b0}}};

  assign beat_take = busy_q & mem_beat_valid_i;
  assign last_beat = cnt_q == icache_pkg::off_w'(icache_pkg::line_words - 1);

  // drop the beat into its slot
  always_comb begin
    line_next = line_q;
    line_next[icache_pkg::word_w*mem_beat_i.idx +: icache_pkg::word_w] = mem_beat_i.data;
  end

  // the fourth beat completes the line in its own cycle
  assign fill_valid_o = beat_take & last_beat;
  assign fill_o.tag   = tag_q;
  assign fill_o.line  = line_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (refill_start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (beat_take) begin
      cnt_q <= cnt_q + 1'b1;  // wraps back to 0 after the last beat
      if (last_beat) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (refill_start_i) tag_q <= refill_tag_i;
    if (beat_take) line_q <= line_next;
  end

  // memory answers only an outstanding read, beats in order
  a_beat_in_order: assert property (@(posedge clk) disable iff (rst)
    mem_beat_valid_i |-> busy_q && mem_beat_i.idx == cnt_q);

  // the fetch port never starts a second miss while one is open
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    refill_start_i |-> !busy_q);

endmodule

// ==== source/icache_plru.sv ====
// victim is the lowest invalid way, else the lowest way with a clear used bit
`timescale 1ns/1ns

module icache_plru #(
  parameter int n_ways = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              touch_i,
  input  logic [n_ways-1:0] hit_way_i,
  input  logic              fill_valid_i,
  output logic [n_ways-1:0] valid_o,
  output logic [n_ways-1:0] victim_o
);

  logic [n_ways-1:0] valid_q;
  logic [n_ways-1:0] used_q;
  logic [n_ways-1:0] cand;     // ways eligible for eviction
  logic [n_ways-1:0] set_vec;  // way accessed this cycle
  logic [n_ways-1:0] used_or;

  // fill invalid ways first, then fall back to the used bits
  assign cand     = (&valid_q) ? ~used_q : ~valid_q;
  assign victim_o = cand & (~cand + 1'b1);  // keep the lowest set bit
  assign valid_o  = valid_q;

  assign set_vec = touch_i ? hit_way_i : victim_o;
  assign used_or = used_q | set_vec;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      used_q  <= '0;
    end else if (touch_i || fill_valid_i) begin
      // all used would leave no victim, so restart from this way alone
      used_q <= (&used_or) ? set_vec : used_or;
      if (fill_valid_i) begin
        valid_q <= valid_q | victim_o;
      end
    end
  end

  // holds only while the used bits never all end up set
  a_victim_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot(victim_o));

  // a hit and a line install never share a cycle
  a_touch_xor_fill: assert property (@(posedge clk) disable iff (rst)
    !(touch_i && fill_valid_i));

endmodule

// ==== source/icache_store.sv ====
// tags and lines have no reset; valid bits come from the replacement logic
`timescale 1ns/1ns

module icache_store #(
  parameter int n_ways   = 4,
  parameter bit cache_en = 1'b1
) (
  input  logic                          clk,
  input  logic [icache_pkg::tag_w-1:0]  lookup_tag_i,
  input  logic [icache_pkg::off_w-1:0]  lookup_offset_i,
  input  logic [n_ways-1:0]             valid_i,
  input  logic [n_ways-1:0]             victim_i,
  input  logic                          fill_valid_i,
  input  icache_pkg::line_fill_t        fill_i,
  output logic                          hit_o,
  output logic [n_ways-1:0]             hit_way_o,
  output logic [icache_pkg::word_w-1:0] hit_word_o
);

  logic [icache_pkg::tag_w-1:0]  tag_q  [n_ways];
  logic [icache_pkg::line_w-1:0] line_q [n_ways];
  logic [n_ways-1:0]             hit_vec;
  logic                          install;

  assign install = fill_valid_i & cache_en;

  // compare against every valid way in parallel
  always_comb begin
    for (int w = 0; w < n_ways; w++) begin
      hit_vec[w] = valid_i[w] & cache_en & (tag_q[w] == lookup_tag_i);
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec;

  // and-or mux, hit_vec is one-hot or zero
  always_comb begin
    hit_word_o = '0;
    for (int w = 0; w < n_ways; w++) begin
      hit_word_o |= {icache_pkg::word_w{hit_vec[w]}}
                  & line_q[w][icache_pkg::word_w*lookup_offset_i +: icache_pkg::word_w];
    end
  end

  // line install into the victim way
  always_ff @(posedge clk) begin
    if (install) begin
      for (int w = 0; w < n_ways; w++) begin
        if (victim_i[w]) begin
          tag_q[w]  <= fill_i.tag;
          line_q[w] <= fill_i.line;
        end
      end
    end
  end

  // a tag lives in one way only
  a_hit_onehot0: assert property (@(posedge clk)
    $onehot0(hit_vec));

endmodule

// ==== source/icache_fetch_port.sv ====
// one request in flight; a new req_valid_i is allowed only after rsp_valid_o
`timescale 1ns/1ns

module icache_fetch_port #(
  parameter bit cache_en = 1'b1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  input  icache_pkg::fetch_req_t        req_i,
  output logic                          rsp_valid_o,
  output icache_pkg::fetch_rsp_t        rsp_o,
  output logic [icache_pkg::tag_w-1:0]  lookup_tag_o,
  output logic [icache_pkg::off_w-1:0]  lookup_offset_o,
  input  logic                          hit_i,
  input  logic [icache_pkg::word_w-1:0] hit_word_i,
  output logic                          touch_o,
  output logic                          refill_start_o,
  output logic [icache_pkg::tag_w-1:0]  refill_tag_o,
  input  logic                          fill_valid_i,
  input  icache_pkg::line_fill_t        fill_i
);

  icache_pkg::fetch_state_e      state_q;
  icache_pkg::fetch_state_e      state_d;
  icache_pkg::fetch_req_t        addr_q;     // latched request address
  logic [icache_pkg::word_w-1:0] rsp_q;      // refill response word
  logic [icache_pkg::word_w-1:0] fill_word;
  logic                          hit_eff;

  // lookup always runs on the latched address
  assign lookup_tag_o    = addr_q.addr[icache_pkg::word_w-1 -: icache_pkg::tag_w];
  assign lookup_offset_o = addr_q.addr[icache_pkg::off_w-1:0];
  assign refill_tag_o    = lookup_tag_o;

  assign hit_eff   = cache_en & hit_i;  // disabled cache misses every time
  assign fill_word = fill_i.line[icache_pkg::word_w*lookup_offset_o +: icache_pkg::word_w];

  always_comb begin
    state_d        = state_q;
    rsp_valid_o    = 1'b0;
    touch_o        = 1'b0;
    refill_start_o = 1'b0;
    case (state_q)
      icache_pkg::IDLE: begin
        if (req_valid_i) state_d = icache_pkg::LOOKUP;
      end
      icache_pkg::LOOKUP: begin
        if (hit_eff) begin
          rsp_valid_o = 1'b1;  // hit answers in the cycle after the request
          touch_o     = 1'b1;
          state_d     = icache_pkg::IDLE;
        end else begin
          refill_start_o = 1'b1;
          state_d        = icache_pkg::REFILL;
        end
      end
      icache_pkg::REFILL: begin
        if (fill_valid_i) state_d = icache_pkg::REPLY;
      end
      icache_pkg::REPLY: begin
        rsp_valid_o = 1'b1;
        state_d     = icache_pkg::IDLE;
      end
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  // refill reply comes from the register, hit reply straight from the store
  assign rsp_o.data = (state_q == icache_pkg::REPLY) ? rsp_q : hit_word_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && state_q == icache_pkg::IDLE) begin
      addr_q <= req_i;
    end
    if (fill_valid_i && state_q == icache_pkg::REFILL) begin
      rsp_q <= fill_word;  // requested word out of the incoming line
    end
  end

  // requester must wait for the response before the next request
  a_req_only_idle: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> state_q == icache_pkg::IDLE);

  // refill engine only completes a line that this port asked for
  a_fill_in_refill: assert property (@(posedge clk) disable iff (rst)
    fill_valid_i |-> state_q == icache_pkg::REFILL);

endmodule

// ==== source/icache_pkg.sv ====
// word-addressed 4-word lines; tag is the word address without its 2-bit line offset
package icache_pkg;

  localparam int word_w     = 32;                   // data and address width
  localparam int line_words = 4;                    // words per line
  localparam int off_w      = $clog2(line_words);   // word offset inside a line
  localparam int line_w     = word_w * line_words;  // 128-bit line
  localparam int tag_w      = word_w - off_w;       // 30-bit tag

  // requester side
  typedef struct packed {
    logic [word_w-1:0] addr;  // word address
  } fetch_req_t;

  typedef struct packed {
    logic [word_w-1:0] data;
  } fetch_rsp_t;

  // refill engine to tag/data store
  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [line_w-1:0] line;  // word 0 in the low bits
  } line_fill_t;

  // one beat of the external line read
  typedef struct packed {
    logic [off_w-1:0]  idx;   // beat index, 0 to 3 in order
    logic [word_w-1:0] data;
  } mem_beat_t;

  // fetch port FSM
  typedef enum logic [1:0] {
    IDLE,    // waiting for a request
    LOOKUP,  // tag compare on the latched address
    REFILL,  // waiting for the line from memory
    REPLY    // registered refill response
  } fetch_state_e;

endpackage
